//--- Bender.yml
package:
  name: ff_layer

sources:
  - files:
      - rtl/ff_pkg.sv
      - rtl/input_buffer.sv
      - rtl/weight_mem.sv
      - rtl/mac_unit.sv
      - rtl/relu_norm.sv
      - rtl/goodness_calc.sv
      - rtl/ff_layer_top.sv
  - target: test
    files:
      - tests/ff_layer_assertions.sv
      - tests/tb_ff_layer.sv

//--- rtl/ff_layer_top.sv
`timescale 1ns/100ps

module ff_layer_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pixel_we,
    input  ff_pkg::pixel_wr_t      pixel,
    input  logic                   weight_we,
    input  ff_pkg::weight_wr_t     weight,
    input  logic                   bias_we,
    input  ff_pkg::bias_wr_t       bias,
    input  logic                   start,
    output logic                   busy,
    output logic                   act_valid,
    output ff_pkg::neuron_result_t act,
    output logic                   goodness_valid,
    output ff_pkg::data_t          goodness
);

    // Shadow capture on an accepted start
    logic                                   capture;
    ff_pkg::data_t [ff_pkg::INPUT_SIZE-1:0] shadow;

    // Weight read path
    ff_pkg::weight_addr_t                   raddr;
    ff_pkg::data_t                          rdata;

    // Raw sums into bias and ReLU
    logic                                   raw_valid;
    ff_pkg::neuron_result_t                 raw;

    input_buffer u_input_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pixel_we (pixel_we),
        .pixel    (pixel),
        .capture  (capture),
        .shadow   (shadow)
    );

    weight_mem u_weight_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (weight_we),
        .wr    (weight),
        .raddr (raddr),
        .rdata (rdata)
    );

    mac_unit u_mac_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .shadow    (shadow),
        .capture   (capture),
        .busy      (busy),
        .raddr     (raddr),
        .rdata     (rdata),
        .raw_valid (raw_valid),
        .raw       (raw)
    );

    relu_norm u_relu_norm (
        .clk       (clk),
        .rst_n     (rst_n),
        .bias_we   (bias_we),
        .bias      (bias),
        .raw_valid (raw_valid),
        .raw       (raw),
        .act_valid (act_valid),
        .act       (act)
    );

    // Goodness taps the activation stream
    goodness_calc u_goodness_calc (
        .clk            (clk),
        .rst_n          (rst_n),
        .act_valid      (act_valid),
        .act            (act),
        .goodness_valid (goodness_valid),
        .goodness       (goodness)
    );

endmodule

//--- rtl/ff_pkg.sv
package ff_pkg;

    // Layer dimensions
    localparam int INPUT_SIZE   = 16;
    localparam int NUM_NEURONS  = 8;

    // Q16.16 fixed point
    localparam int DATA_WIDTH   = 32;
    localparam int FRAC_BITS    = 16;

    // One weight per neuron and input, neuron-major
    localparam int WEIGHT_DEPTH = NUM_NEURONS * INPUT_SIZE;

    typedef logic signed [DATA_WIDTH-1:0]            data_t;
    typedef logic [$clog2(INPUT_SIZE)-1:0]           pixel_idx_t;
    typedef logic [$clog2(NUM_NEURONS)-1:0]          neuron_idx_t;
    typedef logic [$clog2(WEIGHT_DEPTH)-1:0]         weight_addr_t;

    // Write ports into the three storage blocks
    typedef struct packed {
        pixel_idx_t addr;
        data_t      data;
    } pixel_wr_t;

    typedef struct packed {
        weight_addr_t addr;
        data_t        data;
    } weight_wr_t;

    typedef struct packed {
        neuron_idx_t addr;
        data_t       data;
    } bias_wr_t;

    // Per-neuron result, used for raw sums and activations alike
    typedef struct packed {
        neuron_idx_t neuron;
        logic        last;
        data_t       value;
    } neuron_result_t;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_FILL,
        MAC_ACCUM,
        MAC_EMIT
    } mac_state_e;

    // Full signed product, arithmetic shift by FRAC_BITS, low word kept
    function automatic data_t fx_mul(input data_t a, input data_t b);
        logic signed [2*DATA_WIDTH-1:0] p;
        p = a * b;
        return p[FRAC_BITS +: DATA_WIDTH];
    endfunction

endpackage

//--- rtl/goodness_calc.sv
`timescale 1ns/100ps

module goodness_calc (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   act_valid,
    input  ff_pkg::neuron_result_t act,
    output logic                   goodness_valid,
    output ff_pkg::data_t          goodness
);

    ff_pkg::data_t acc;
    ff_pkg::data_t square;
    ff_pkg::data_t total;

    // Truncated square of the incoming activation
    assign square = ff_pkg::fx_mul(act.value, act.value);
    assign total  = acc + square;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc            <= '0;
            goodness       <= '0;
            goodness_valid <= 1'b0;
        end else begin
            goodness_valid <= 1'b0;
            if (act_valid) begin
                if (act.last) begin
                    // Pass done, publish and restart from zero
                    goodness       <= total;
                    goodness_valid <= 1'b1;
                    acc            <= '0;
                end else begin
                    acc <= total;
                end
            end
        end
    end

endmodule

//--- rtl/input_buffer.sv
`timescale 1ns/100ps

module input_buffer (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    pixel_we,
    input  ff_pkg::pixel_wr_t                       pixel,
    input  logic                                    capture,
    output ff_pkg::data_t [ff_pkg::INPUT_SIZE-1:0]  shadow
);

    // Live image, written by the host at any time
    ff_pkg::data_t [ff_pkg::INPUT_SIZE-1:0] live;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live <= '0;
        end else if (pixel_we) begin
            live[pixel.addr] <= pixel.data;
        end
    end

    // Shadow copy held for the running pass
    // A pixel written in the capture cycle goes straight into the shadow
    genvar gi;
    generate
        for (gi = 0; gi < ff_pkg::INPUT_SIZE; gi++) begin : g_shadow
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    shadow[gi] <= '0;
                end else if (capture) begin
                    if (pixel_we && pixel.addr == ff_pkg::pixel_idx_t'(gi)) begin
                        shadow[gi] <= pixel.data;
                    end else begin
                        shadow[gi] <= live[gi];
                    end
                end
            end
        end
    endgenerate

endmodule

//--- rtl/mac_unit.sv
`timescale 1ns/100ps

module mac_unit (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  ff_pkg::data_t [ff_pkg::INPUT_SIZE-1:0]  shadow,
    output logic                                    capture,
    output logic                                    busy,
    output ff_pkg::weight_addr_t                    raddr,
    input  ff_pkg::data_t                           rdata,
    output logic                                    raw_valid,
    output ff_pkg::neuron_result_t                  raw
);

    localparam ff_pkg::pixel_idx_t  LAST_PIXEL  = ff_pkg::pixel_idx_t'(ff_pkg::INPUT_SIZE - 1);
    localparam ff_pkg::neuron_idx_t LAST_NEURON =
        ff_pkg::neuron_idx_t'(ff_pkg::NUM_NEURONS - 1);

    ff_pkg::mac_state_e  state;
    ff_pkg::neuron_idx_t neuron_cnt;
    // Index of the pixel whose weight arrives this cycle
    ff_pkg::pixel_idx_t  in_idx;
    // Index of the weight requested this cycle
    ff_pkg::pixel_idx_t  rd_idx;
    ff_pkg::data_t       acc;

    // Start only counts while idle
    assign busy    = (state != ff_pkg::MAC_IDLE);
    assign capture = start && !busy;

    // Fill requests input 0, accumulate runs one address ahead
    assign rd_idx = (state == ff_pkg::MAC_ACCUM) ? ff_pkg::pixel_idx_t'(in_idx + 1'b1) : '0;
    // Sizes are powers of two, so the concatenation is n * INPUT_SIZE + i
    assign raddr  = {neuron_cnt, rd_idx};

    // Sum leaves in the emit cycle
    assign raw_valid  = (state == ff_pkg::MAC_EMIT);
    assign raw.neuron = neuron_cnt;
    assign raw.last   = (neuron_cnt == LAST_NEURON);
    assign raw.value  = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ff_pkg::MAC_IDLE;
            neuron_cnt <= '0;
            in_idx     <= '0;
            acc        <= '0;
        end else begin
            case (state)
                ff_pkg::MAC_IDLE: begin
                    if (start) begin
                        neuron_cnt <= '0;
                        state      <= ff_pkg::MAC_FILL;
                    end
                end
                // Memory read in flight, accumulator cleared
                ff_pkg::MAC_FILL: begin
                    acc    <= '0;
                    in_idx <= '0;
                    state  <= ff_pkg::MAC_ACCUM;
                end
                ff_pkg::MAC_ACCUM: begin
                    acc    <= acc + ff_pkg::fx_mul(rdata, shadow[in_idx]);
                    in_idx <= in_idx + 1'b1;
                    if (in_idx == LAST_PIXEL) begin
                        state <= ff_pkg::MAC_EMIT;
                    end
                end
                ff_pkg::MAC_EMIT: begin
                    if (neuron_cnt == LAST_NEURON) begin
                        state <= ff_pkg::MAC_IDLE;
                    end else begin
                        neuron_cnt <= neuron_cnt + 1'b1;
                        state      <= ff_pkg::MAC_FILL;
                    end
                end
                default: begin
                    state <= ff_pkg::MAC_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/relu_norm.sv
`timescale 1ns/100ps

module relu_norm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   bias_we,
    input  ff_pkg::bias_wr_t       bias,
    input  logic                   raw_valid,
    input  ff_pkg::neuron_result_t raw,
    output logic                   act_valid,
    output ff_pkg::neuron_result_t act
);

    // One bias per neuron
    ff_pkg::data_t bias_mem [ff_pkg::NUM_NEURONS];
    ff_pkg::data_t biased;

    // Wrapping add, same as the sums upstream
    assign biased = raw.value + bias_mem[raw.neuron];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ff_pkg::NUM_NEURONS; i++) begin
                bias_mem[i] <= '0;
            end
        end else if (bias_we) begin
            bias_mem[bias.addr] <= bias.data;
        end
    end

    // Registered activation, one cycle behind raw_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_valid <= 1'b0;
            act       <= '0;
        end else begin
            act_valid <= raw_valid;
            if (raw_valid) begin
                act.neuron <= raw.neuron;
                act.last   <= raw.last;
                // ReLU on the sign bit
                act.value  <= biased[ff_pkg::DATA_WIDTH-1] ? '0 : biased;
            end
        end
    end

endmodule

//--- rtl/weight_mem.sv
`timescale 1ns/100ps

module weight_mem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we,
    input  ff_pkg::weight_wr_t   wr,
    input  ff_pkg::weight_addr_t raddr,
    output ff_pkg::data_t        rdata
);

    // Neuron n, input i at n * INPUT_SIZE + i
    ff_pkg::data_t mem [ff_pkg::WEIGHT_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ff_pkg::WEIGHT_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            // Host load port
            if (we) begin
                mem[wr.addr] <= wr.data;
            end
            // Sequencer read, one cycle latency
            rdata <= mem[raddr];
        end
    end

endmodule

//--- sources.f
rtl/ff_pkg.sv
rtl/input_buffer.sv
rtl/weight_mem.sv
rtl/mac_unit.sv
rtl/relu_norm.sv
rtl/goodness_calc.sv
rtl/ff_layer_top.sv
tests/ff_layer_assertions.sv
tests/tb_ff_layer.sv

//--- tests/ff_layer_assertions.sv
`timescale 1ns/100ps

module ff_layer_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   busy,
    input logic                   act_valid,
    input ff_pkg::neuron_result_t act,
    input logic                   goodness_valid,
    input logic                   weight_we,
    input logic                   bias_we
);

    // Failures seen so far, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // Outputs quiet while reset holds
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !busy && !act_valid && !goodness_valid)
        else begin
            $error("busy or a valid strobe active during reset");
            fail_cnt++;
        end

    // Loads only while idle
    a_no_load_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !weight_we && !bias_we)
        else begin
            $error("weight or bias write while busy");
            fail_cnt++;
        end

    // Only the final activation trails busy by one cycle
    a_act_in_pass: assert property (@(posedge clk) disable iff (!rst_n)
        act_valid && !busy |-> $past(busy) && act.last)
        else begin
            $error("activation strobe outside a pass");
            fail_cnt++;
        end

    a_good_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        goodness_valid |-> $past(act_valid && act.last))
        else begin
            $error("goodness strobe without a preceding last activation");
            fail_cnt++;
        end

endmodule

bind ff_layer_top ff_layer_assertions u_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .busy           (busy),
    .act_valid      (act_valid),
    .act            (act),
    .goodness_valid (goodness_valid),
    .weight_we      (weight_we),
    .bias_we        (bias_we)
);

//--- tests/tb_ff_layer.sv
`timescale 1ns/100ps

module tb_ff_layer;

    // Budget covers 7 passes plus one idle watch window and the load cycles
    localparam int PASS_CYCLES    = ff_pkg::NUM_NEURONS * (ff_pkg::INPUT_SIZE + 2);
    localparam int TIMEOUT_CYCLES = 8 * PASS_CYCLES + 220 + 200;

    logic clk = 1'b0;
    logic rst_n = 1'b1;
    logic pixel_we, weight_we, bias_we, start;
    ff_pkg::pixel_wr_t      pixel;
    ff_pkg::weight_wr_t     weight;
    ff_pkg::bias_wr_t       bias;
    logic                   busy, act_valid, goodness_valid;
    ff_pkg::neuron_result_t act;
    ff_pkg::data_t          goodness;

    // Reference copies of everything loaded into the DUT
    ff_pkg::data_t px_model [ff_pkg::INPUT_SIZE];
    ff_pkg::data_t w_model [ff_pkg::WEIGHT_DEPTH];
    ff_pkg::data_t b_model [ff_pkg::NUM_NEURONS];
    ff_pkg::neuron_result_t exp_act [$];
    ff_pkg::data_t          exp_good [$];

    logic [31:0] rng = 32'h3db4a5e5;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int starts = 0;
    int good_cnt = 0;
    int neg_cnt = 0;
    int cycles = 0;
    int err_mark;

    ff_layer_top dut0 (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // 0.0 up to 1.0 in Q16.16
    function automatic ff_pkg::data_t rand_unit();
        return ff_pkg::data_t'(next_rand() % 32'h0001_0001);
    endfunction

    // -1.0 up to +1.0 in Q16.16
    function automatic ff_pkg::data_t rand_signed();
        return ff_pkg::data_t'(int'(next_rand() % 32'h0002_0001) - 32'sh0001_0000);
    endfunction

    // Q16.16 product as the low word of the shifted 64-bit signed product
    function automatic ff_pkg::data_t mul_q16(ff_pkg::data_t a, ff_pkg::data_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return ff_pkg::data_t'(p >>> ff_pkg::FRAC_BITS);
    endfunction

    // Expected activation stream and goodness for the image as loaded now
    function automatic void predict_pass();
        ff_pkg::data_t sum;
        ff_pkg::data_t biased;
        ff_pkg::data_t good;
        ff_pkg::neuron_result_t r;
        good = '0;
        neg_cnt = 0;
        for (int n = 0; n < ff_pkg::NUM_NEURONS; n++) begin
            sum = '0;
            for (int i = 0; i < ff_pkg::INPUT_SIZE; i++) begin
                sum = sum + mul_q16(w_model[n * ff_pkg::INPUT_SIZE + i], px_model[i]);
            end
            biased = sum + b_model[n];
            r.neuron = ff_pkg::neuron_idx_t'(n);
            r.last = (n == ff_pkg::NUM_NEURONS - 1);
            // ReLU
            r.value = (biased < 0) ? '0 : biased;
            if (biased < 0) begin
                neg_cnt++;
            end
            exp_act.push_back(r);
            good = good + mul_q16(r.value, r.value);
        end
        exp_good.push_back(good);
    endfunction

    // Move to the drive point after the next rising edge with all strobes low
    task automatic next_slot();
        @(posedge clk);
        #10;
        pixel_we = 1'b0;
        weight_we = 1'b0;
        bias_we = 1'b0;
        start = 1'b0;
    endtask

    task automatic write_pixel(int idx, ff_pkg::data_t val);
        next_slot();
        pixel_we = 1'b1;
        pixel.addr = ff_pkg::pixel_idx_t'(idx);
        pixel.data = val;
        px_model[idx] = val;
    endtask

    task automatic write_weight(int idx, ff_pkg::data_t val);
        next_slot();
        weight_we = 1'b1;
        weight.addr = ff_pkg::weight_addr_t'(idx);
        weight.data = val;
        w_model[idx] = val;
    endtask

    task automatic write_bias(int idx, ff_pkg::data_t val);
        next_slot();
        bias_we = 1'b1;
        bias.addr = ff_pkg::neuron_idx_t'(idx);
        bias.data = val;
        b_model[idx] = val;
    endtask

    // One-cycle start strobe in the current slot with the expected results queued
    task automatic raise_start();
        checks++;
        assert (!busy) else begin
            $display("start issued while the engine was still busy");
            errors++;
        end
        start = 1'b1;
        predict_pass();
        starts++;
        next_slot();
    endtask

    // Start strobe in the next free slot
    task automatic issue_start();
        next_slot();
        raise_start();
    endtask

    // Block until every accepted start has produced its goodness
    task automatic wait_done();
        while (good_cnt < starts) begin
            @(negedge clk);
        end
        checks++;
        assert (exp_act.size() == 0) else begin
            $display("pass ended with %0d activations missing", exp_act.size());
            errors++;
        end
    endtask

    task automatic report(string name);
        tests++;
        $display("test %0d %s: %s (%0d errors)", tests, name,
                 (errors == err_mark) ? "ok" : "bad", errors - err_mark);
        err_mark = errors;
    endtask

    // Output monitor on the falling edge where registered outputs are settled
    always @(negedge clk) begin
        if (rst_n && act_valid) begin
            checks++;
            assert (exp_act.size() != 0) else begin
                $display("activation strobe arrived with no pass pending");
                errors++;
            end
            if (exp_act.size() != 0) begin
                assert (act == exp_act[0]) else begin
                    $display("ERR act expected %h got %h", exp_act[0], act);
                    errors++;
                end
                void'(exp_act.pop_front());
            end
        end
        if (rst_n && goodness_valid) begin
            good_cnt++;
            checks++;
            assert (exp_good.size() != 0 && goodness == exp_good[0]) else begin
                $display("ERR goodness expected %h got %h",
                         (exp_good.size() != 0) ? exp_good[0] : 'x, goodness);
                errors++;
            end
            if (exp_good.size() != 0) begin
                void'(exp_good.pop_front());
            end
        end
    end

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, a pass never completed", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        pixel_we = 1'b0;
        weight_we = 1'b0;
        bias_we = 1'b0;
        start = 1'b0;
        pixel = '0;
        weight = '0;
        bias = '0;
        for (int i = 0; i < ff_pkg::INPUT_SIZE; i++) px_model[i] = '0;
        for (int i = 0; i < ff_pkg::WEIGHT_DEPTH; i++) w_model[i] = '0;
        for (int i = 0; i < ff_pkg::NUM_NEURONS; i++) b_model[i] = '0;
        err_mark = 0;
        #5 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #10 rst_n = 1'b1;

        // Reset state and a pass over cleared memories
        checks++;
        assert (!busy && !act_valid && !goodness_valid) else begin
            $display("busy or a valid strobe is high right after reset");
            errors++;
        end
        issue_start();
        wait_done();
        report("reset and zero pass");

        // Full random load
        for (int i = 0; i < ff_pkg::WEIGHT_DEPTH; i++) write_weight(i, rand_signed());
        for (int i = 0; i < ff_pkg::NUM_NEURONS; i++) write_bias(i, rand_signed());
        for (int i = 0; i < ff_pkg::INPUT_SIZE; i++) write_pixel(i, rand_unit());
        issue_start();
        wait_done();
        report("random pass");

        // Biases of -8.0 force ReLU clamping
        write_bias(0, 32'shFFF8_0000);
        write_bias(5, 32'shFFF8_0000);
        issue_start();
        checks++;
        assert (neg_cnt > 0) else begin
            $display("stimulus produced no negative neuron");
            errors++;
        end
        wait_done();
        report("relu clamp and goodness");

        // New image loads while the current one runs from the shadow
        issue_start();
        for (int i = 0; i < ff_pkg::INPUT_SIZE; i++) begin
            write_pixel(i, rand_unit());
            checks++;
            assert (busy) else begin
                $display("engine went idle before the pixel reload finished");
                errors++;
            end
        end
        wait_done();
        // A pixel written together with start joins the captured image
        write_pixel(5, rand_unit());
        raise_start();
        wait_done();
        report("shadow capture");

        // Start while busy must be dropped
        issue_start();
        repeat (3) next_slot();
        checks++;
        assert (busy) else begin
            $display("engine not busy when the extra start was issued");
            errors++;
        end
        start = 1'b1;
        next_slot();
        wait_done();
        repeat (PASS_CYCLES + 4) @(negedge clk);
        checks++;
        assert (good_cnt == starts) else begin
            $display("ERR goodness_valid count expected %h got %h", starts, good_cnt);
            errors++;
        end
        report("start while busy");

        // Partial reload between passes
        for (int i = 0; i < 12; i++) begin
            write_weight(int'(next_rand() % ff_pkg::WEIGHT_DEPTH), rand_signed());
        end
        write_bias(2, rand_signed());
        write_bias(7, rand_signed());
        issue_start();
        wait_done();
        report("weight and bias reload");

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, dut0.u_assertions.fail_cnt);
        if (errors == 0 && dut0.u_assertions.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
